// ==== wt_write_path_pkg.sv ====
//============================================================
// widths and vector types of the write-through store path,
// imported by the RTL blocks and by the testbench
//============================================================
package wt_write_path_pkg;

   // front-end store port, one word per store
   localparam int FE_DATA_W = 32;
   localparam int FE_NBYTES = FE_DATA_W / 8;

   // back-end memory bus
   localparam int BE_DATA_W = 64;
   localparam int BE_NBYTES = BE_DATA_W / 8;

   // front-end words packed in one back-end word
   localparam int LANES  = BE_DATA_W / FE_DATA_W;
   localparam int LANE_W = $clog2(LANES);  // lane select taken from the word address

   // store payload as seen on the front end
   typedef logic [FE_DATA_W-1:0] fe_data_t;
   typedef logic [FE_NBYTES-1:0] fe_strb_t;

   // back-end write word and its byte enables
   typedef logic [BE_DATA_W-1:0] be_data_t;
   typedef logic [BE_NBYTES-1:0] be_strb_t;

endpackage

// ==== fe_write_port.sv ====
//============================================================
// front-end store stage, holds one store and pushes it into
// the write buffer; stores without any strobe are dropped
//============================================================
`timescale 1ns/100ps

module fe_write_port
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W = 12
) (
   input  logic              clk_i,
   input  logic              reset_i,

   // front-end store port
   input  logic              fe_valid_i,
   input  logic [ADDR_W-1:0] fe_addr_i,
   input  fe_strb_t          fe_wstrb_i,
   input  fe_data_t          fe_wdata_i,
   output logic              fe_ready_o,

   // buffer write side
   input  logic              full_i,
   output logic              push_o,
   output logic [ADDR_W-1:0] push_addr_o,
   output fe_strb_t          push_strb_o,
   output fe_data_t          push_data_o
);

   logic hold_vld;  // hold register occupied
   logic accept;
   logic load;

   assign push_o = hold_vld & ~full_i;

   // free slot, or the slot empties this cycle
   assign fe_ready_o = ~hold_vld | push_o;

   assign accept = fe_valid_i & fe_ready_o;
   assign load   = accept & (|fe_wstrb_i);  // no strobe, nothing to write

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         hold_vld <= 1'b0;
      end else if (load) begin
         hold_vld <= 1'b1;  // also covers push and reload in one cycle
      end else if (push_o) begin
         hold_vld <= 1'b0;
      end
   end

   // store payload, only meaningful while hold_vld
   always_ff @(posedge clk_i) begin
      if (load) begin
         push_addr_o <= fe_addr_i;
         push_strb_o <= fe_wstrb_i;
         push_data_o <= fe_wdata_i;
      end
   end

   // a store stalled on a full buffer keeps its payload until pushed
   a_hold_stall: assert property (
      @(posedge clk_i) disable iff (reset_i)
      hold_vld && !push_o |=> hold_vld && $stable(push_addr_o)
                              && $stable(push_strb_o) && $stable(push_data_o)
   );

endmodule

// ==== write_buffer.sv ====
//============================================================
// show-ahead FIFO of pending stores between the front-end
// stage and the back-end write channel
//============================================================
`timescale 1ns/100ps

module write_buffer
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W    = 12,
   parameter int BUF_DEPTH = 4  // power of two
) (
   input  logic              clk_i,
   input  logic              reset_i,

   // write side
   input  logic              push_i,
   input  logic [ADDR_W-1:0] push_addr_i,
   input  fe_strb_t          push_strb_i,
   input  fe_data_t          push_data_i,
   output logic              full_o,

   // read side, head valid while not empty
   input  logic              pop_i,
   output logic              empty_o,
   output logic [ADDR_W-1:0] head_addr_o,
   output fe_strb_t          head_strb_o,
   output fe_data_t          head_data_o
);

   localparam int PTR_W = $clog2(BUF_DEPTH);

   logic [ADDR_W-1:0] addr_mem [BUF_DEPTH];
   fe_strb_t          strb_mem [BUF_DEPTH];
   fe_data_t          data_mem [BUF_DEPTH];

   logic [PTR_W:0]   wr_ptr;  // msb is the wrap bit
   logic [PTR_W:0]   rd_ptr;
   logic [PTR_W-1:0] wr_idx;
   logic [PTR_W-1:0] rd_idx;

   assign wr_idx = wr_ptr[PTR_W-1:0];
   assign rd_idx = rd_ptr[PTR_W-1:0];

   assign empty_o = (wr_ptr == rd_ptr);
   // same slot, different lap
   assign full_o  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) && (wr_idx == rd_idx);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         addr_mem[wr_idx] <= push_addr_i;
         strb_mem[wr_idx] <= push_strb_i;
         data_mem[wr_idx] <= push_data_i;
      end
   end

   // head read straight from the array
   assign head_addr_o = addr_mem[rd_idx];
   assign head_strb_o = strb_mem[rd_idx];
   assign head_data_o = data_mem[rd_idx];

   // overflow, unless the head leaves in the same cycle
   a_no_overflow: assert property (
      @(posedge clk_i) disable iff (reset_i)
      push_i && full_o |-> pop_i
   );

   // underflow
   a_no_underflow: assert property (
      @(posedge clk_i) disable iff (reset_i)
      pop_i |-> !empty_o
   );

endmodule

// ==== be_write_channel.sv ====
//============================================================
// back-end write channel, presents buffered stores on the
// 64-bit memory bus and pops each one on its acknowledge
//============================================================
`timescale 1ns/100ps

module be_write_channel
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W = 12
) (
   input  logic              clk_i,
   input  logic              reset_i,

   // buffer head
   input  logic              empty_i,
   input  logic [ADDR_W-1:0] head_addr_i,  // front-end word address
   input  fe_strb_t          head_strb_i,
   input  fe_data_t          head_data_i,
   output logic              pop_o,

   // memory bus
   output logic              be_valid_o,
   output logic [ADDR_W+1:0] be_addr_o,  // byte address
   output be_data_t          be_wdata_o,
   output be_strb_t          be_wstrb_o,
   input  logic              be_ack_i
);

   // low byte-address bits cleared on the bus
   localparam int BYTE_OFF_W = LANE_W + $clog2(FE_NBYTES);

   typedef enum logic {
      WR_IDLE,
      WR_WRITE
   } wr_state_t;

   wr_state_t         state;
   wr_state_t         state_nxt;
   logic [LANE_W-1:0] lane;
   logic              presenting;

   assign lane = head_addr_i[LANE_W-1:0];

   // in write state with an entry at the head
   assign presenting = (state == WR_WRITE) & ~empty_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= WR_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         WR_IDLE: begin
            if (!empty_i) begin
               state_nxt = WR_WRITE;
            end
         end
         default: begin  // WR_WRITE
            // stay for back-to-back entries, leave once drained
            if (empty_i) begin
               state_nxt = WR_IDLE;
            end
         end
      endcase
   end

   // valid drops in the acknowledge cycle, as the head is popped
   assign be_valid_o = presenting & ~be_ack_i;
   assign pop_o      = presenting & be_ack_i;

   // aligned to the back-end word
   assign be_addr_o  = {head_addr_i[ADDR_W-1:LANE_W], {BYTE_OFF_W{1'b0}}};

   // same word in every lane, strobes pick the one written
   assign be_wdata_o = {LANES{head_data_i}};

   always_comb begin
      be_wstrb_o = '0;
      if (presenting) begin
         be_wstrb_o = be_strb_t'(head_strb_i) << (lane * FE_NBYTES);
      end
   end

   // bus word holds from the rise of valid through the acknowledge
   a_be_stable: assert property (
      @(posedge clk_i) disable iff (reset_i)
      be_valid_o |=> $stable(be_addr_o) && $stable(be_wdata_o)
                     && $stable(be_wstrb_o)
   );

endmodule

// ==== wt_write_path.sv ====
//============================================================
// write path of the write-through cache, front-end store
// stage, write buffer and back-end write channel in series
//============================================================
`timescale 1ns/100ps

module wt_write_path
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W    = 12,
   parameter int BUF_DEPTH = 4
) (
   input  logic              clk_i,
   input  logic              reset_i,

   // front-end store port
   input  logic              fe_valid_i,
   input  logic [ADDR_W-1:0] fe_addr_i,
   input  fe_strb_t          fe_wstrb_i,
   input  fe_data_t          fe_wdata_i,
   output logic              fe_ready_o,

   // back-end memory bus
   output logic              be_valid_o,
   output logic [ADDR_W+1:0] be_addr_o,
   output be_data_t          be_wdata_o,
   output be_strb_t          be_wstrb_o,
   input  logic              be_ack_i
);

   // store stage to buffer
   logic              push;
   logic [ADDR_W-1:0] push_addr;
   fe_strb_t          push_strb;
   fe_data_t          push_data;
   logic              full;

   // buffer to channel
   logic              empty;
   logic [ADDR_W-1:0] head_addr;
   fe_strb_t          head_strb;
   fe_data_t          head_data;
   logic              pop;

   fe_write_port #(
      .ADDR_W(ADDR_W)
   ) u_fe_write_port (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .fe_valid_i (fe_valid_i),
      .fe_addr_i  (fe_addr_i),
      .fe_wstrb_i (fe_wstrb_i),
      .fe_wdata_i (fe_wdata_i),
      .fe_ready_o (fe_ready_o),
      .full_i     (full),
      .push_o     (push),
      .push_addr_o(push_addr),
      .push_strb_o(push_strb),
      .push_data_o(push_data)
   );

   write_buffer #(
      .ADDR_W   (ADDR_W),
      .BUF_DEPTH(BUF_DEPTH)
   ) u_write_buffer (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (push),
      .push_addr_i(push_addr),
      .push_strb_i(push_strb),
      .push_data_i(push_data),
      .full_o     (full),
      .pop_i      (pop),
      .empty_o    (empty),
      .head_addr_o(head_addr),
      .head_strb_o(head_strb),
      .head_data_o(head_data)
   );

   be_write_channel #(
      .ADDR_W(ADDR_W)
   ) u_be_write_channel (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .empty_i    (empty),
      .head_addr_i(head_addr),
      .head_strb_i(head_strb),
      .head_data_i(head_data),
      .pop_o      (pop),
      .be_valid_o (be_valid_o),
      .be_addr_o  (be_addr_o),
      .be_wdata_o (be_wdata_o),
      .be_wstrb_o (be_wstrb_o),
      .be_ack_i   (be_ack_i)
   );

endmodule

// ==== tb_write_checker.sv ====
//============================================================
// checker for the write-path testbench, predicts each back-end
// write from accepted stores and compares it on the acknowledge
//============================================================
`timescale 1ns/100ps

module tb_write_checker
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W = 12
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              fe_valid_i,
   input  logic              fe_ready_i,
   input  logic [ADDR_W-1:0] fe_addr_i,
   input  fe_strb_t          fe_wstrb_i,
   input  fe_data_t          fe_wdata_i,
   input  logic              be_valid_i,
   input  logic              be_ack_i,
   input  logic [ADDR_W+1:0] be_addr_i,
   input  be_data_t          be_wdata_i,
   input  be_strb_t          be_wstrb_i,
   input  int                test_id_i,
   input  logic              test_done_i,
   input  logic              expect_stall_i,
   output int                pending_o,
   output int                passes_o,
   output int                errors_o
);

   logic [ADDR_W+1:0] exp_addr_q [$];
   be_data_t          exp_data_q [$];
   be_strb_t          exp_strb_q [$];

   logic reset_checked;
   int   test_writes;
   int   test_stalls;  // cycles with a store waiting on fe_ready
   int   test_err_base;

   // clear the lane bit, then 4 bytes per front-end word
   function automatic logic [ADDR_W+1:0] aligned_addr(input logic [ADDR_W-1:0] word_addr);
      logic [ADDR_W+1:0] wide;
      wide = {2'b00, word_addr & ~ADDR_W'(1)};
      return wide << 2;
   endfunction

   function automatic be_strb_t lane_strb(input fe_strb_t strb, input logic upper);
      return upper ? {strb, 4'b0000} : {4'b0000, strb};
   endfunction

   function automatic int field_errors(input string name, input logic [63:0] exp_v,
                                       input logic [63:0] act_v);
      if (exp_v !== act_v) begin
         $display("Error at time %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
         return 1;
      end
      return 0;
   endfunction

   always @(posedge clk_i) begin : monitor
      int bad;
      if (reset_i) begin
         exp_addr_q.delete();
         exp_data_q.delete();
         exp_strb_q.delete();
         reset_checked = 1'b0;
         test_writes   = 0;
         test_stalls   = 0;
         test_err_base = 0;
         passes_o      = 0;
         errors_o      = 0;
      end else begin
         if (!reset_checked) begin
            bad = field_errors("be_valid_o", 64'(1'b0), 64'(be_valid_i))
                + field_errors("fe_ready_o", 64'(1'b1), 64'(fe_ready_i));
            if (bad == 0) passes_o++;
            errors_o += bad;
            reset_checked = 1'b1;
         end
         // one write per acknowledge in the write state
         if (be_ack_i && be_wstrb_i != '0) begin
            test_writes++;
            if (exp_addr_q.size() == 0) begin
               $display("back-end write at time %0t with no front-end store queued for it",
                        $time);
               errors_o++;
            end else begin
               bad = field_errors("be_addr_o", 64'(exp_addr_q.pop_front()), 64'(be_addr_i))
                   + field_errors("be_wdata_o", exp_data_q.pop_front(), be_wdata_i)
                   + field_errors("be_wstrb_o", 64'(exp_strb_q.pop_front()), 64'(be_wstrb_i));
               if (bad == 0) passes_o++;
               errors_o += bad;
            end
         end
         // a store without strobes must never reach the bus
         if (be_ack_i && be_wstrb_i == '0) begin
            $display("back-end write at time %0t was presented without any byte strobe",
                     $time);
            errors_o++;
         end
         if (fe_valid_i && fe_ready_i && fe_wstrb_i != '0) begin
            exp_addr_q.push_back(aligned_addr(fe_addr_i));
            exp_data_q.push_back({fe_wdata_i, fe_wdata_i});
            exp_strb_q.push_back(lane_strb(fe_wstrb_i, fe_addr_i[0]));
         end
         if (fe_valid_i && !fe_ready_i) test_stalls++;
         if (test_done_i) begin
            if (expect_stall_i && test_stalls == 0) begin
               $display("fe_ready_o never went low although the write buffer was held full");
               errors_o++;
            end else if (expect_stall_i) begin
               passes_o++;
            end
            $display("test %0d done: %0d back-end writes checked, %0d errors",
                     test_id_i, test_writes, errors_o - test_err_base);
            test_writes   = 0;
            test_stalls   = 0;
            test_err_base = errors_o;
         end
      end
      pending_o = exp_addr_q.size();
   end

endmodule

// ==== tb_wt_write_path.sv ====
//============================================================
// testbench top for the write path, applies the store table
// and answers back-end writes with a delayed acknowledge
//============================================================
`timescale 1ns/100ps

module tb_wt_write_path
   import wt_write_path_pkg::*;
#(
   parameter int ADDR_W    = 12,
   parameter int BUF_DEPTH = 4
);

   localparam int READY_TIMEOUT = 200;  // cycles
   localparam int DRAIN_TIMEOUT = 500;
   localparam int RAND_ACK      = 255;  // row takes a random ack delay

   typedef struct packed {
      int                test;
      logic [ADDR_W-1:0] addr;
      fe_strb_t          strb;
      fe_data_t          data;
      int                gap;  // idle cycles before the store
      int                ack;  // cycles from valid to acknowledge
   } row_t;

   logic              clk_i;
   logic              reset_i;
   logic              fe_valid_i;
   logic [ADDR_W-1:0] fe_addr_i;
   fe_strb_t          fe_wstrb_i;
   fe_data_t          fe_wdata_i;
   logic              fe_ready_o;
   logic              be_valid_o;
   logic [ADDR_W+1:0] be_addr_o;
   be_data_t          be_wdata_o;
   be_strb_t          be_wstrb_o;
   logic              be_ack_i;

   int   test_id;
   logic test_done;
   logic expect_stall;
   int   pending;
   int   passes;
   int   errors;
   int   seed;
   logic timed_out;
   row_t rows [$];
   int   ack_delay_q [$];  // one per store that writes, in order

   wt_write_path #(
      .ADDR_W   (ADDR_W),
      .BUF_DEPTH(BUF_DEPTH)
   ) UUT (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .fe_valid_i(fe_valid_i),
      .fe_addr_i (fe_addr_i),
      .fe_wstrb_i(fe_wstrb_i),
      .fe_wdata_i(fe_wdata_i),
      .fe_ready_o(fe_ready_o),
      .be_valid_o(be_valid_o),
      .be_addr_o (be_addr_o),
      .be_wdata_o(be_wdata_o),
      .be_wstrb_o(be_wstrb_o),
      .be_ack_i  (be_ack_i)
   );

   tb_write_checker #(
      .ADDR_W(ADDR_W)
   ) u_checker (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .fe_valid_i    (fe_valid_i),
      .fe_ready_i    (fe_ready_o),
      .fe_addr_i     (fe_addr_i),
      .fe_wstrb_i    (fe_wstrb_i),
      .fe_wdata_i    (fe_wdata_i),
      .be_valid_i    (be_valid_o),
      .be_ack_i      (be_ack_i),
      .be_addr_i     (be_addr_o),
      .be_wdata_i    (be_wdata_o),
      .be_wstrb_i    (be_wstrb_o),
      .test_id_i     (test_id),
      .test_done_i   (test_done),
      .expect_stall_i(expect_stall),
      .pending_o     (pending),
      .passes_o      (passes),
      .errors_o      (errors)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic void add_row(input int test, input logic [ADDR_W-1:0] addr,
                                   input fe_strb_t strb, input fe_data_t data,
                                   input int gap, input int ack);
      row_t row;
      row.test = test;
      row.addr = addr;
      row.strb = strb;
      row.data = data;
      row.gap  = gap;
      row.ack  = ack;
      rows.push_back(row);
   endfunction

   function automatic void build_table();
      int               i;
      logic [ADDR_W-1:0] r_addr;
      fe_strb_t         r_strb;
      fe_data_t         r_data;
      add_row(2, 12'h010, 4'hf, 32'hdead_beef, 1, 2);  // even words, lower lane
      add_row(2, 12'h3a4, 4'h3, 32'h1234_5678, 2, 0);
      add_row(2, 12'h002, 4'h1, 32'h0000_00a5, 0, 1);
      add_row(3, 12'h011, 4'hc, 32'hcafe_f00d, 1, 1);  // odd words, upper lane
      add_row(3, 12'h3a5, 4'h2, 32'h8765_4321, 0, 3);
      add_row(3, 12'h7ff, 4'h9, 32'h55aa_33cc, 2, 0);
      add_row(4, 12'h020, 4'h0, 32'hffff_ffff, 1, 0);  // no strobe, no write
      add_row(4, 12'h021, 4'h8, 32'h0bad_cafe, 0, 2);
      add_row(4, 12'h022, 4'h0, 32'h0f0f_0f0f, 0, 0);
      add_row(4, 12'h023, 4'h6, 32'h1357_9bdf, 0, 0);
      // slow acknowledges against back-to-back stores
      for (i = 0; i < 8; i++) begin
         add_row(5, ADDR_W'(12'h100 + i), 4'hf, 32'ha5a5_0000 + i, 0, (i == 3) ? RAND_ACK : 6);
      end
      for (i = 0; i < 12; i++) begin
         r_addr = ADDR_W'($random(seed));
         r_strb = fe_strb_t'($random(seed));
         r_data = $random(seed);
         add_row(6, r_addr, r_strb, r_data, 0, 0);
      end
   endfunction

   task automatic report_timeout(input string reason);
      $display("%s", reason);
      timed_out = 1'b1;
   endtask

   task automatic apply_row(input row_t row);
      int waited;
      repeat (row.gap) @(negedge clk_i);
      if (row.strb != '0) begin
         if (row.ack == RAND_ACK) ack_delay_q.push_back($random(seed) & 7);
         else ack_delay_q.push_back(row.ack);
      end
      fe_valid_i = 1'b1;
      fe_addr_i  = row.addr;
      fe_wstrb_i = row.strb;
      fe_wdata_i = row.data;
      waited     = 0;
      while (!fe_ready_o && waited < READY_TIMEOUT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!fe_ready_o) begin
         report_timeout($sformatf("store to word %h was never accepted, fe_ready_o stuck low",
                                  row.addr));
      end else begin
         @(negedge clk_i);  // taken on the rising edge in between
         fe_valid_i = 1'b0;
      end
   endtask

   task automatic end_test(input int id, input logic stall);
      int waited;
      waited = 0;
      while (pending != 0 && waited < DRAIN_TIMEOUT) begin
         @(negedge clk_i);
         waited++;
      end
      if (pending != 0) begin
         report_timeout($sformatf("%0d stores never reached the back end in test %0d",
                                  pending, id));
      end else begin
         test_id      = id;
         expect_stall = stall;
         test_done    = 1'b1;
         @(negedge clk_i);
         test_done = 1'b0;
      end
   endtask

   // back-end responder, one acknowledge per presented write
   initial begin : ack_responder
      int delay;
      be_ack_i = 1'b0;
      forever begin
         @(negedge clk_i);
         if (!reset_i && be_valid_o) begin
            delay = (ack_delay_q.size() > 0) ? ack_delay_q.pop_front() : 0;
            repeat (delay) @(negedge clk_i);
            be_ack_i = 1'b1;
            @(negedge clk_i);
            be_ack_i = 1'b0;
         end
      end
   end

   initial begin : stimulus
      int t;
      int r;
      seed         = 32'hd85df65d;
      timed_out    = 1'b0;
      reset_i      = 1'b1;
      fe_valid_i   = 1'b0;
      fe_addr_i    = '0;
      fe_wstrb_i   = '0;
      fe_wdata_i   = '0;
      test_id      = 0;
      test_done    = 1'b0;
      expect_stall = 1'b0;
      build_table();
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      end_test(1, 1'b0);  // reset values
      r = 0;
      for (t = 2; t <= 6 && !timed_out; t++) begin
         while (r < rows.size() && rows[r].test == t && !timed_out) begin
            apply_row(rows[r]);
            r++;
         end
         if (!timed_out) begin
            end_test(t, t == 5);
         end
      end
      $display("totals: %0d passed, %0d failed", passes, errors);
      if (errors == 0 && !timed_out) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== wt_write_path.f ====
wt_write_path_pkg.sv
fe_write_port.sv
write_buffer.sv
be_write_channel.sv
wt_write_path.sv
tb_write_checker.sv
tb_wt_write_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the write-path testbench.
# Exit status is nonzero unless the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_wt_write_path -f wt_write_path.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^All checks passed$" \
   && echo "simulation PASSED" \
   || { echo "simulation FAILED"; exit 1; }
